/* hw/dart_defs.svh */
`ifndef DART_DEFS_SVH
`define DART_DEFS_SVH

// Host link
`define DART_WORD_W      16
`define DART_BIT_CYCLES  8     // Stands in for the baud divisor

// Simulator core
`define DART_NODES       4
`define DART_TIME_W      12    // Width of the RUN tick count

// Link buffering
`define DART_FIFO_DEPTH  4

`endif

/* hw/dart_host_pkg.sv */
`include "dart_defs.svh"

package dart_host_pkg;

    typedef enum logic [3:0] {
        OP_CONFIG = 4'h1,  // Rate words follow, node 0 first
        OP_RUN    = 4'h2,  // Arg holds the tick count
        OP_STATS  = 4'h3,  // Reply with one count per node
        OP_CLEAR  = 4'h4,
        OP_DONE   = 4'h5   // Sent back when a run ends
    } opcode_e;

    typedef struct packed {
        opcode_e                  opcode;
        logic [`DART_WORD_W-5:0]  arg;
    } host_word_t;

    // Sticky link faults, shown on the LEDs
    typedef struct packed {
        logic rx_error;
        logic tx_error;
        logic control_error;
    } link_status_t;

endpackage

/* hw/dart_sim_pkg.sv */
package dart_sim_pkg;

    typedef logic [15:0] rate_t;   // Injection threshold
    typedef logic [15:0] count_t;  // Saturating injection count

    // Control strobes into the simulator core
    typedef struct packed {
        logic   enable;        // Run in progress
        logic   clear;         // Zero all counters
        logic   config_valid;  // Shift config_word into the rate chain
        rate_t  config_word;
        logic   stats_shift;   // Rotate the next count to stats_word
        logic   measure;       // Counters follow injections
    } sim_ctrl_t;

endpackage

/* hw/word_port.sv */
`include "dart_defs.svh"

module word_port (
    input  logic                     clock_50,
    input  logic                     arst_n,
    input  logic                     rs232_rx,
    output logic                     rs232_tx,
    output dart_host_pkg::host_word_t rx_word,
    output logic                     rx_valid,
    input  logic                     rx_ready,
    input  dart_host_pkg::host_word_t tx_word,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    output logic                     rx_error,
    output logic                     tx_error
);

    localparam int CNT_W = $clog2(`DART_BIT_CYCLES);

    logic [1:0]       rx_sync;
    logic             rx_line;
    logic             rx_prev;
    logic             rx_busy;
    logic [CNT_W-1:0] rx_cnt;
    logic [3:0]       rx_bit;
    logic [7:0]       rx_shift;
    logic [7:0]       rx_high;
    logic             rx_second;  // High byte already captured
    logic             rx_sample;
    logic             rx_done;
    logic             rx_drop;

    logic             tx_busy;
    logic [CNT_W-1:0] tx_cnt;
    logic [4:0]       tx_bit;
    logic [18:0]      tx_frame;
    logic             tx_pend;
    logic             tx_abort;
    logic             tx_load;

    assign rx_line   = rx_sync[1];
    assign rx_sample = rx_busy && (rx_cnt == '0);
    assign rx_done   = rx_sample && (rx_bit == 4'd9) && rx_line && rx_second;
    assign rx_drop   = rx_done && rx_valid && !rx_ready;  // Receive FIFO full

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_sync   <= 2'b11;
            rx_prev   <= 1'b1;
            rx_busy   <= 1'b0;
            rx_cnt    <= '0;
            rx_bit    <= '0;
            rx_second <= 1'b0;
            rx_valid  <= 1'b0;
            rx_error  <= 1'b0;
        end
        else
        begin
            rx_sync <= {rx_sync[0], rs232_rx};
            rx_prev <= rx_line;
            if (rx_valid && rx_ready)
                rx_valid <= 1'b0;
            if (!rx_busy)
            begin
                if (rx_prev && !rx_line)  // Falling edge of a start bit
                begin
                    rx_busy <= 1'b1;
                    rx_cnt  <= CNT_W'(`DART_BIT_CYCLES / 2 - 1);
                    rx_bit  <= '0;
                end
            end
            else if (rx_sample)
            begin
                rx_cnt <= CNT_W'(`DART_BIT_CYCLES - 1);
                rx_bit <= rx_bit + 4'd1;
                if (rx_bit == 4'd0 && rx_line)
                    rx_busy <= 1'b0;      // Glitch, not a start bit
                else if (rx_bit == 4'd9)
                begin
                    rx_busy <= 1'b0;
                    if (!rx_line)
                    begin
                        rx_error  <= 1'b1;  // Framing error, restart pairing
                        rx_second <= 1'b0;
                    end
                    else
                        rx_second <= !rx_second;
                end
            end
            else
                rx_cnt <= rx_cnt - 1'b1;
            if (rx_done && !rx_drop)
                rx_valid <= 1'b1;
            if (rx_drop)
                rx_error <= 1'b1;
        end
    end

    always_ff @(posedge clock_50)
    begin
        if (rx_sample && rx_bit >= 4'd1 && rx_bit <= 4'd8)
            rx_shift <= {rx_line, rx_shift[7:1]};  // LSB first
        if (rx_sample && rx_bit == 4'd9 && !rx_second)
            rx_high <= rx_shift;
        if (rx_done && !rx_drop)
            rx_word <= dart_host_pkg::host_word_t'({rx_high, rx_shift});
    end

    assign tx_ready = !tx_busy;
    assign tx_load  = tx_valid && tx_ready;

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tx_busy  <= 1'b0;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            rs232_tx <= 1'b1;
            tx_pend  <= 1'b0;
            tx_abort <= 1'b0;
            tx_error <= 1'b0;
        end
        else
        begin
            tx_pend <= tx_valid && !tx_ready;
            if (tx_pend && !tx_valid)
                tx_abort <= 1'b1;  // Offer withdrawn before it was taken
            if (tx_valid && tx_busy && tx_bit == 5'd19 && tx_abort)
                tx_error <= 1'b1;
            if (tx_load)
            begin
                tx_busy  <= 1'b1;
                tx_cnt   <= CNT_W'(`DART_BIT_CYCLES - 1);
                tx_bit   <= '0;
                rs232_tx <= 1'b0;  // Start bit of the high byte
            end
            else if (tx_busy)
            begin
                if (tx_cnt == '0)
                begin
                    tx_cnt <= CNT_W'(`DART_BIT_CYCLES - 1);
                    if (tx_bit == 5'd19)
                    begin
                        tx_busy  <= 1'b0;
                        tx_abort <= 1'b0;
                        rs232_tx <= 1'b1;
                    end
                    else
                    begin
                        tx_bit   <= tx_bit + 5'd1;
                        rs232_tx <= tx_frame[0];
                    end
                end
                else
                    tx_cnt <= tx_cnt - 1'b1;
            end
        end
    end

    // Bits after the first start bit, sent from bit 0 upward
    always_ff @(posedge clock_50)
    begin
        if (tx_load)
            tx_frame <= {1'b1, tx_word[7:0], 1'b0, 1'b1, tx_word[15:8]};
        else if (tx_busy && tx_cnt == '0)
            tx_frame <= {1'b1, tx_frame[18:1]};
    end

    a_tx_hold: assert property (@(posedge clock_50) disable iff (!arst_n)
        (tx_valid && !tx_ready) |=> (!tx_valid || $stable(tx_word)));

endmodule

/* hw/word_fifo.sv */
`include "dart_defs.svh"

module word_fifo #(
    parameter type payload_t = logic [`DART_WORD_W-1:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clock_50,
    input  logic     arst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = count != CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock_50)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    a_no_overflow: assert property (@(posedge clock_50) disable iff (!arst_n)
        count <= CNT_W'(DEPTH));
    // Entries between the pointers match the count, so reads never pass writes
    a_no_underflow: assert property (@(posedge clock_50) disable iff (!arst_n)
        ((int'(rd_ptr) + int'(count)) % DEPTH) == int'(wr_ptr));

endmodule

/* hw/dart_control.sv */
`include "dart_defs.svh"

module dart_control (
    input  logic                      clock_50,
    input  logic                      arst_n,
    input  dart_host_pkg::host_word_t cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    output dart_host_pkg::host_word_t reply,
    output logic                      reply_valid,
    input  logic                      reply_ready,
    output dart_sim_pkg::sim_ctrl_t   sim_ctrl,
    input  dart_sim_pkg::count_t      stats_word,
    output logic                      start,
    output logic [`DART_TIME_W-1:0]   run_ticks,
    input  logic                      done,
    output logic                      control_error
);

    localparam int IDX_W = $clog2(`DART_NODES);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUNNING,
        REPLY_DONE,
        STREAM,
        CLEAR
    } state_e;

    state_e           state;
    logic [IDX_W-1:0] idx;  // Node index in LOAD and STREAM
    logic             last_idx;

    assign cmd_ready   = (state == IDLE) || (state == LOAD);
    assign reply_valid = (state == REPLY_DONE) || (state == STREAM);
    assign last_idx    = idx == IDX_W'(`DART_NODES - 1);

    always_comb
    begin
        reply = dart_host_pkg::host_word_t'(stats_word);
        if (state == REPLY_DONE)
        begin
            reply.opcode = dart_host_pkg::OP_DONE;
            reply.arg    = run_ticks;  // Echo the tick count
        end
    end

    always_comb
    begin
        sim_ctrl.enable       = state == RUNNING;
        sim_ctrl.measure      = state == RUNNING;
        sim_ctrl.clear        = state == CLEAR;
        sim_ctrl.config_valid = (state == LOAD) && cmd_valid;
        sim_ctrl.config_word  = dart_sim_pkg::rate_t'(cmd);
        sim_ctrl.stats_shift  = (state == STREAM) && reply_ready;
    end

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state         <= IDLE;
            idx           <= '0;
            start         <= 1'b0;
            run_ticks     <= '0;
            control_error <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                IDLE:
                    if (cmd_valid)
                    begin
                        idx <= '0;
                        case (cmd.opcode)
                            dart_host_pkg::OP_CONFIG: state <= LOAD;
                            dart_host_pkg::OP_STATS:  state <= STREAM;
                            dart_host_pkg::OP_CLEAR:  state <= CLEAR;
                            dart_host_pkg::OP_RUN:
                            begin
                                state     <= RUNNING;
                                start     <= 1'b1;
                                run_ticks <= cmd.arg;
                            end
                            default: control_error <= 1'b1;  // Word is dropped
                        endcase
                    end
                LOAD:
                    if (cmd_valid)
                    begin
                        idx <= idx + 1'b1;
                        if (last_idx)
                            state <= IDLE;
                    end
                RUNNING:
                    if (done)
                        state <= REPLY_DONE;
                REPLY_DONE:
                    if (reply_ready)
                        state <= IDLE;
                STREAM:
                    if (reply_ready)
                    begin
                        idx <= idx + 1'b1;
                        if (last_idx)
                            state <= IDLE;
                    end
                CLEAR:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    a_start_pulse: assert property (@(posedge clock_50) disable iff (!arst_n)
        start |=> !start);

endmodule

/* hw/sim_timer.sv */
`include "dart_defs.svh"

module sim_timer (
    input  logic                    clock_50,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic [`DART_TIME_W-1:0] run_ticks,
    output logic                    tick,
    output logic                    done
);

    logic [`DART_TIME_W-1:0] remaining;  // Ticks still to issue

    assign tick = remaining != '0;

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            remaining <= '0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                remaining <= run_ticks;
                done      <= run_ticks == '0;  // Empty run ends at once
            end
            else if (tick)
            begin
                remaining <= remaining - 1'b1;
                done      <= remaining == `DART_TIME_W'(1);
            end
        end
    end

endmodule

/* hw/sim_core.sv */
`include "dart_defs.svh"

module sim_core (
    input  logic                    clock_50,
    input  logic                    arst_n,
    input  dart_sim_pkg::sim_ctrl_t sim_ctrl,
    input  logic                    tick,
    output dart_sim_pkg::count_t    stats_word
);

    localparam int N = `DART_NODES;

    dart_sim_pkg::rate_t  rate  [N];
    dart_sim_pkg::count_t count [N];
    logic [15:0]          lfsr  [N];
    logic [N-1:0]         inject;
    logic                 step;

    assign step       = tick && sim_ctrl.enable;
    assign stats_word = count[0];

    // A rate of all ones must inject even on the largest sample
    always_comb
    begin
        for (int i = 0; i < N; i++)
            inject[i] = (lfsr[i] < rate[i]) || (&rate[i]);
    end

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < N; i++)
            begin
                rate[i] <= '0;
                lfsr[i] <= 16'hACE1 ^ 16'(i * 16'h1357);  // Distinct nonzero seeds
            end
        end
        else
        begin
            if (sim_ctrl.config_valid)
            begin
                for (int i = 0; i < N - 1; i++)
                    rate[i] <= rate[i + 1];
                rate[N - 1] <= sim_ctrl.config_word;  // Node 0 lands last in rate[0]
            end
            if (step)
            begin
                for (int i = 0; i < N; i++)
                    lfsr[i] <= {1'b0, lfsr[i][15:1]} ^ (lfsr[i][0] ? 16'hB400 : 16'h0000);
            end
        end
    end

    always_ff @(posedge clock_50 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < N; i++)
                count[i] <= '0;
        end
        else if (sim_ctrl.clear)
        begin
            for (int i = 0; i < N; i++)
                count[i] <= '0;
        end
        else if (sim_ctrl.stats_shift)
        begin
            for (int i = 0; i < N - 1; i++)
                count[i] <= count[i + 1];
            count[N - 1] <= count[0];  // Rotate so a full readout restores order
        end
        else if (step && sim_ctrl.measure)
        begin
            for (int i = 0; i < N; i++)
                if (inject[i] && !(&count[i]))
                    count[i] <= count[i] + 1'b1;
        end
    end

endmodule

/* hw/dart.sv */
`include "dart_defs.svh"

module dart (
    input  logic       clock_50,
    input  logic       arst_n,
    input  logic [3:0] sw,
    input  logic       rs232_rx,
    output logic       rs232_tx,
    output logic [3:0] led
);

    dart_host_pkg::host_word_t   rx_word;
    dart_host_pkg::host_word_t   cmd;
    dart_host_pkg::host_word_t   reply;
    dart_host_pkg::host_word_t   tx_word;
    dart_host_pkg::link_status_t status;
    dart_sim_pkg::sim_ctrl_t     sim_ctrl;
    dart_sim_pkg::count_t        stats_word;

    logic                    rx_valid;
    logic                    rx_ready;
    logic                    cmd_valid;
    logic                    cmd_ready;
    logic                    reply_valid;
    logic                    reply_ready;
    logic                    tx_valid;
    logic                    tx_ready;
    logic                    rx_error;
    logic                    tx_error;
    logic                    control_error;
    logic                    start;
    logic [`DART_TIME_W-1:0] run_ticks;
    logic                    tick;
    logic                    done;

    assign status = '{rx_error: rx_error, tx_error: tx_error, control_error: control_error};

    // Debug view, LEDs active high
    always_comb
    begin
        case (sw)
            4'd0:    led = {1'b0, status};
            4'd1:    led = {sim_ctrl.measure, sim_ctrl.enable, tick, done};
            4'd2:    led = {2'b00, rs232_rx, rs232_tx};
            default: led = 4'b0000;
        endcase
    end

    word_port i_word_port (
        .clock_50 (clock_50),
        .arst_n   (arst_n),
        .rs232_rx (rs232_rx),
        .rs232_tx (rs232_tx),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_word  (tx_word),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_error (rx_error),
        .tx_error (tx_error)
    );

    word_fifo #(.payload_t(dart_host_pkg::host_word_t), .DEPTH(`DART_FIFO_DEPTH)) i_rx_fifo (
        .clock_50  (clock_50),
        .arst_n    (arst_n),
        .in_data   (rx_word),
        .in_valid  (rx_valid),
        .in_ready  (rx_ready),
        .out_data  (cmd),
        .out_valid (cmd_valid),
        .out_ready (cmd_ready)
    );

    word_fifo #(.payload_t(dart_host_pkg::host_word_t), .DEPTH(`DART_FIFO_DEPTH)) i_tx_fifo (
        .clock_50  (clock_50),
        .arst_n    (arst_n),
        .in_data   (reply),
        .in_valid  (reply_valid),
        .in_ready  (reply_ready),
        .out_data  (tx_word),
        .out_valid (tx_valid),
        .out_ready (tx_ready)
    );

    dart_control i_dart_control (
        .clock_50      (clock_50),
        .arst_n        (arst_n),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .reply         (reply),
        .reply_valid   (reply_valid),
        .reply_ready   (reply_ready),
        .sim_ctrl      (sim_ctrl),
        .stats_word    (stats_word),
        .start         (start),
        .run_ticks     (run_ticks),
        .done          (done),
        .control_error (control_error)
    );

    sim_timer i_sim_timer (
        .clock_50  (clock_50),
        .arst_n    (arst_n),
        .start     (start),
        .run_ticks (run_ticks),
        .tick      (tick),
        .done      (done)
    );

    sim_core i_sim_core (
        .clock_50   (clock_50),
        .arst_n     (arst_n),
        .sim_ctrl   (sim_ctrl),
        .tick       (tick),
        .stats_word (stats_word)
    );

endmodule

/* bench/uart_host.sv */
`include "dart_defs.svh"

module uart_host (
    input  logic        clock_50,
    input  logic [15:0] send_word,
    input  logic        send_valid,
    input  logic        send_bad,      // Send only the high byte, with its stop bit low
    output logic        line_out,      // To the DUT receive pin
    input  logic        line_in,       // From the DUT transmit pin
    output logic [15:0] recv_word,
    output logic        recv_valid,
    output logic        recv_frame_ok
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT = `DART_BIT_CYCLES;

    logic [16:0] pending [$];  // {bad, word} in send order

    task automatic send_bit(input logic level);
        line_out <= level;
        repeat (BIT) @(posedge clock_50);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic stop);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++)
            send_bit(data[i]);     // LSB first
        send_bit(stop);
    endtask

    // Samples each bit in its middle, on the falling clock edge
    task automatic recv_byte(output logic [7:0] data, output logic stop);
        @(negedge clock_50);
        while (line_in !== 1'b0)
            @(negedge clock_50);
        repeat (BIT / 2) @(negedge clock_50);
        for (int i = 0; i < 8; i++)
        begin
            repeat (BIT) @(negedge clock_50);
            data[i] = line_in;
        end
        repeat (BIT) @(negedge clock_50);
        stop = line_in;
    endtask

    always @(posedge clock_50)
    begin
        if (send_valid)
            pending.push_back({send_bad, send_word});
    end

    initial
    begin
        logic [16:0] item;
        line_out = 1'b1;
        forever
        begin
            if (pending.size() == 0)
                @(posedge clock_50);
            else
            begin
                item = pending.pop_front();
                if (item[16])
                begin
                    send_byte(item[15:8], 1'b0);
                    send_bit(1'b1);  // Idle so the next start bit has an edge
                    send_bit(1'b1);
                end
                else
                begin
                    send_byte(item[15:8], 1'b1);  // High byte first
                    send_byte(item[7:0], 1'b1);
                end
            end
        end
    end

    initial
    begin
        logic [7:0] high;
        logic [7:0] low;
        logic       stop_high;
        logic       stop_low;
        recv_word     = '0;
        recv_valid    = 1'b0;
        recv_frame_ok = 1'b1;
        forever
        begin
            recv_byte(high, stop_high);
            recv_byte(low, stop_low);
            @(posedge clock_50);
            recv_word     <= {high, low};
            recv_frame_ok <= stop_high && stop_low;
            recv_valid    <= 1'b1;
            @(posedge clock_50);
            recv_valid    <= 1'b0;
        end
    end

endmodule

/* bench/dart_tb.sv */
`include "dart_defs.svh"

module dart_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT         = `DART_BIT_CYCLES;
    localparam int NODES       = `DART_NODES;
    localparam int MAX_TICKS   = 200;
    localparam int WORDS       = 60;            // Words sent plus replies, rounded up
    localparam int LED_WAIT    = 3 * 20 * BIT;  // Cycles for a flag to reach its LED
    localparam int WATCHDOG_NS = 10 * (WORDS * 20 * BIT + 2 * MAX_TICKS + 4000);

    logic        clock_50;
    logic        arst_n;
    logic [3:0]  sw;
    logic        rs232_rx;
    logic        rs232_tx;
    logic [3:0]  led;

    logic [15:0] send_word;
    logic        send_valid;
    logic        send_bad;
    logic [15:0] recv_word;
    logic        recv_valid;
    logic        recv_frame_ok;

    logic [15:0] cmd_q [$];  // Words to send back to back
    logic [15:0] got_q [$];  // Replies from the DUT
    logic [15:0] rates [NODES];
    integer      seed;
    int          n_ticks;

    dart i_dart (
        .clock_50 (clock_50),
        .arst_n   (arst_n),
        .sw       (sw),
        .rs232_rx (rs232_rx),
        .rs232_tx (rs232_tx),
        .led      (led)
    );

    uart_host i_uart_host (
        .clock_50      (clock_50),
        .send_word     (send_word),
        .send_valid    (send_valid),
        .send_bad      (send_bad),
        .line_out      (rs232_rx),
        .line_in       (rs232_tx),
        .recv_word     (recv_word),
        .recv_valid    (recv_valid),
        .recv_frame_ok (recv_frame_ok)
    );

    initial
    begin
        clock_50 = 1'b0;
        forever #5 clock_50 = ~clock_50;
    end

    always @(posedge clock_50)
    begin
        if (recv_valid)
            got_q.push_back(recv_word);
    end

    task automatic fail_now();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        fail_now();
    endtask

    function automatic logic [15:0] cmd_word(input logic [3:0] op, input logic [11:0] arg);
        return {op, arg};
    endfunction

    // All ones injects on every tick, zero never injects
    function automatic logic [15:0] expected_count(input logic [15:0] rate, input int ticks);
        return (rate == 16'hFFFF) ? 16'(ticks) : 16'h0000;
    endfunction

    task automatic send_queued();
        while (cmd_q.size() != 0)
        begin
            @(posedge clock_50);
            send_word  <= cmd_q.pop_front();
            send_bad   <= 1'b0;
            send_valid <= 1'b1;
        end
        @(posedge clock_50);
        send_valid <= 1'b0;
    endtask

    task automatic queue_config();
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_CONFIG, 12'h000));
        for (int i = 0; i < NODES; i++)
            cmd_q.push_back(rates[i]);  // Node 0 first
    endtask

    task automatic expect_word(input logic [15:0] exp, input string name);
        logic [15:0] got;
        while (got_q.size() == 0)
            @(posedge clock_50);
        got = got_q.pop_front();
        assert (got === exp)
        else
            mismatch(name, got, exp);
    endtask

    task automatic compare_stats(input int ticks);
        for (int i = 0; i < NODES; i++)
            expect_word(expected_count(rates[i], ticks), $sformatf("count of node %0d", i));
    endtask

    task automatic wait_led(input int idx, input logic value, input string name);
        int waited;
        waited = 0;
        while (led[idx] !== value && waited < LED_WAIT)
        begin
            @(negedge clock_50);
            waited++;
        end
        assert (led[idx] === value)
        else
            mismatch(name, 16'(led[idx]), 16'(value));
    endtask

    task automatic line_idle();
        repeat (2 * BIT)
        begin
            @(negedge clock_50);
            assert (led[0] === 1'b1)
            else
                mismatch("led[0]", 16'(led[0]), 16'h0001);
        end
    endtask

    a_led_line: assert property (@(posedge clock_50) disable iff (!arst_n)
        (sw == 4'd2) |-> (led == {2'b00, rs232_rx, rs232_tx}))
    else
        mismatch("led", 16'($sampled(led)),
                 16'({2'b00, $sampled(rs232_rx), $sampled(rs232_tx)}));

    a_led_unused: assert property (@(posedge clock_50) disable iff (!arst_n)
        (sw > 4'd2) |-> (led == 4'b0000))
    else
        mismatch("led", 16'($sampled(led)), 16'h0000);

    // The FIFO never withdraws a reply, so tx_error stays low
    a_no_tx_error: assert property (@(posedge clock_50) disable iff (!arst_n)
        (sw == 4'd0) |-> (led[3] == 1'b0 && led[1] == 1'b0))
    else
        mismatch("led[3] and led[1]", 16'({$sampled(led[3]), $sampled(led[1])}), 16'h0000);

    a_reply_framed: assert property (@(posedge clock_50) recv_valid |-> recv_frame_ok)
    else
    begin
        $display("A reply word from the DUT ended with a low stop bit");
        fail_now();
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run took longer than %0d ns", WATCHDOG_NS);
        fail_now();
    end

    initial
    begin
        seed       = 32'hc6ee7faf;
        arst_n     = 1'b0;
        sw         = 4'd0;
        send_word  = '0;
        send_valid = 1'b0;
        send_bad   = 1'b0;
        for (int i = 0; i < NODES; i++)
            rates[i] = (i % 2 == 1) ? 16'hFFFF : 16'h0000;

        repeat (2) @(posedge clock_50);
        @(negedge clock_50);
        assert (rs232_tx === 1'b1 && led === 4'b0000)
        else
        begin
            $display("The serial line or the error LEDs were not idle during reset");
            fail_now();
        end
        repeat (2) @(posedge clock_50);
        arst_n <= 1'b1;

        // Configure, run and read back
        sw <= 4'd7;
        n_ticks = 1 + ($unsigned($random(seed)) % MAX_TICKS);
        queue_config();
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_RUN, 12'(n_ticks)));
        send_queued();
        expect_word(cmd_word(dart_host_pkg::OP_DONE, 12'(n_ticks)), "DONE reply");
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        send_queued();
        compare_stats(n_ticks);

        cmd_q.push_back(cmd_word(dart_host_pkg::OP_CLEAR, 12'h000));
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        send_queued();
        compare_stats(0);

        // Line level view around a readout
        sw <= 4'd2;
        line_idle();
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        send_queued();
        compare_stats(0);
        line_idle();

        sw <= 4'd0;
        cmd_q.push_back(cmd_word(4'h0, 12'h0AB));  // Opcode 0 is not a command
        send_queued();
        wait_led(0, 1'b1, "led[0]");
        assert (led[2] === 1'b0)
        else
            mismatch("led[2]", 16'(led[2]), 16'h0000);
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        send_queued();
        compare_stats(0);

        // One byte with a framing error
        @(posedge clock_50);
        send_word  <= 16'h3C00;
        send_bad   <= 1'b1;
        send_valid <= 1'b1;
        @(posedge clock_50);
        send_valid <= 1'b0;
        send_bad   <= 1'b0;
        wait_led(2, 1'b1, "led[2]");
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        send_queued();
        compare_stats(0);

        // Whole sequence queued without gaps
        n_ticks = 1 + ($unsigned($random(seed)) % MAX_TICKS);
        queue_config();
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_RUN, 12'(n_ticks)));
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_CLEAR, 12'h000));
        cmd_q.push_back(cmd_word(dart_host_pkg::OP_STATS, 12'h000));
        send_queued();
        expect_word(cmd_word(dart_host_pkg::OP_DONE, 12'(n_ticks)), "DONE reply");
        compare_stats(n_ticks);
        compare_stats(0);

        repeat (20 * BIT) @(posedge clock_50);  // Room for a stray reply
        if (got_q.size() != 0)
        begin
            $display("%0d reply words arrived that no command asked for", got_q.size());
            fail_now();
        end
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* list.f */
+incdir+hw
hw/dart_host_pkg.sv
hw/dart_sim_pkg.sv
hw/word_port.sv
hw/word_fifo.sv
hw/dart_control.sv
hw/sim_timer.sv
hw/sim_core.sv
hw/dart.sv
bench/uart_host.sv
bench/dart_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module dart_tb -f list.f -o dart_sim

run: compile
	./obj_dir/dart_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log
